/* compile.f */
source/oledPkg.sv
source/oledInit.sv
source/oledFill.sv
source/oledSequencer.sv
source/i2cWriter.sv
source/oledCtrl.sv
dv/i2cSlaveModel.sv
dv/oledCtrl_checker.sv
dv/oledTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the oledCtrl testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f compile.f --top-module oledTb -o simv \
	&& ./obj_dir/simv +verilator+error+limit+100 | tee sim.log \
	|| { echo "build or simulation did not run"; exit 1; }
grep -q "^Result: PASSED$" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "pass line not found in sim.log"; exit 1; }

/* dv/oledTb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oledTb
// directed tests for the OLED controller
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module oledTb import oledPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClkDiv     = 2;
	localparam int Pages      = 8;
	localparam int Columns    = 128;
	localparam int XferCycles = (2 + 27) * 4 * ClkDiv + 4;	// start, bits, stop, gap
	localparam int FillXfers  = Pages * (3 + Columns);
	localparam int CycleLimit = (2 * InitLen + 2 * FillXfers + 40) * XferCycles;

	logic        CLOCK = 1'b0;
	logic        RST_n, initStart, fillStart, nackArm;
	logic [7:0]  fillData;
	logic        ready, busy, scl, sdaOe, ackError, sda, tripleValid;
	logic [23:0] triple;
	logic [23:0] rxQ [$];	// decoded transfers, oldest first
	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	integer      seed = 32'hede;

	always #10 CLOCK = ~CLOCK;

	oledCtrl #(.ClkDiv(ClkDiv), .Pages(Pages), .Columns(Columns)) i_dut (
		.CLOCK(CLOCK), .RST_n(RST_n), .initStart(initStart), .fillStart(fillStart),
		.fillData(fillData), .ready(ready), .busy(busy), .scl(scl), .sdaOe(sdaOe),
		.ackError(ackError), .sdaIn(sda)
	);

	i2cSlaveModel i_slave (
		.CLOCK(CLOCK), .RST_n(RST_n), .scl(scl), .sdaOe(sdaOe), .sda(sda),
		.nackArm(nackArm), .tripleValid(tripleValid), .triple(triple)
	);

	always @(posedge CLOCK) begin
		if (tripleValid) rxQ.push_back(triple);
	end

	always @(posedge CLOCK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == CycleLimit) begin
			$display("timeout, tests still running after %0d cycles", CycleLimit);
			$display("checks %0d, errors %0d", checkCount, errorCount);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED at %0d ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
		end
	endtask

	task automatic resetDut();
		RST_n <= 1'b0;
		repeat (8) @(posedge CLOCK);
		RST_n <= 1'b1;
		@(posedge CLOCK);
		rxQ.delete();
	endtask

	task automatic startFill(input logic [7:0] pat);
		@(posedge CLOCK);
		fillData <= pat;
		fillStart <= 1'b1;
		@(posedge CLOCK);
		fillStart <= 1'b0;
	endtask

	task automatic startInit(input logic nack);
		@(posedge CLOCK);
		initStart <= 1'b1;
		nackArm <= nack;	// model NACKs the first address byte
		@(posedge CLOCK);
		initStart <= 1'b0;
		nackArm <= 1'b0;
	endtask

	// next decoded transfer, waits on the bus model
	task automatic expectTriple(input logic [7:0] ctrl, input logic [7:0] payload,
		input string what);
		logic [23:0] t;
		while (rxQ.size() == 0) @(posedge CLOCK);
		t = rxQ.pop_front();
		checkValue(32'(t[23:16]), 32'h78, {what, " address"});
		checkValue(32'(t[15:8]), 32'(ctrl), {what, " control"});
		checkValue(32'(t[7:0]), 32'(payload), {what, " payload"});
	endtask

	task automatic expectInit(input string tag);
		for (int i = 0; i < InitLen; i++) begin
			expectTriple(8'h00, initTable[i], $sformatf("%s command %0d", tag, i));
		end
	endtask

	task automatic expectFill(input logic [7:0] pat);
		for (int p = 0; p < Pages; p++) begin
			expectTriple(8'h00, 8'hB0 + 8'(p), $sformatf("page %0d select", p));
			expectTriple(8'h00, 8'h00, $sformatf("page %0d column low", p));
			expectTriple(8'h00, 8'h10, $sformatf("page %0d column high", p));
			for (int c = 0; c < Columns; c++) begin
				expectTriple(8'h40, pat, $sformatf("page %0d column %0d", p, c));
			end
		end
	endtask

	task automatic afterReset();
		checkValue(32'(scl), 1, "scl after reset");
		checkValue(32'(sdaOe), 0, "sdaOe after reset");
		checkValue(32'(ready), 0, "ready after reset");
		checkValue(32'(busy), 0, "busy after reset");
		checkValue(32'(ackError), 0, "ackError after reset");
		repeat (2 * XferCycles) @(posedge CLOCK);
		checkValue(32'(rxQ.size()), 0, "transfers after reset");
	endtask

	task automatic fillBeforeInit();
		logic sawBusy;
		sawBusy = 1'b0;
		startFill(8'h5A);
		repeat (2 * XferCycles) begin
			@(posedge CLOCK);
			sawBusy = sawBusy | busy;
		end
		checkValue(32'(sawBusy), 0, "busy on fill before init");
		checkValue(32'(rxQ.size()), 0, "transfers on fill before init");
	endtask

	task automatic initSequence();
		startInit(1'b0);
		expectInit("init");
		checkValue(32'(ready), 0, "ready before last command done");	// rises after done
		while (!ready) @(posedge CLOCK);
		checkValue(32'(busy), 0, "busy after init");
		checkValue(32'(ackError), 0, "ackError after init");
	endtask

	task automatic fillScreen();
		logic [7:0] pat;
		pat = 8'($random(seed));
		startFill(pat);
		@(posedge CLOCK);
		checkValue(32'(busy), 1, "busy after fill accept");
		expectFill(pat);
		checkValue(32'(busy), 1, "busy at last fill transfer");	// falls after done
		while (busy) @(posedge CLOCK);
		checkValue(32'(ackError), 0, "ackError after fill");
	endtask

	// second request mid-fill is dropped, not queued
	task automatic busyDrop();
		logic [7:0] pat;
		pat = 8'($random(seed));
		startFill(pat);
		repeat (3 * XferCycles) @(posedge CLOCK);
		checkValue(32'(busy), 1, "busy during fill");
		startFill(~pat);
		expectFill(pat);
		while (busy) @(posedge CLOCK);
		repeat (2 * XferCycles) @(posedge CLOCK);
		checkValue(32'(rxQ.size()), 0, "transfers after dropped fill");
	endtask

	task automatic nackRecovery();
		resetDut();
		checkValue(32'(ackError), 0, "ackError after second reset");
		startInit(1'b1);
		expectTriple(8'h00, initTable[0], "nacked command 0");
		checkValue(32'(ackError), 1, "ackError after NACK");
		for (int i = 1; i < InitLen; i++) begin
			expectTriple(8'h00, initTable[i], $sformatf("post-NACK command %0d", i));
		end
		while (!ready) @(posedge CLOCK);
		checkValue(32'(ackError), 1, "ackError sticky");
	endtask

	initial begin
		RST_n = 1'b0;
		initStart = 1'b0;
		fillStart = 1'b0;
		fillData = 8'h00;
		nackArm = 1'b0;
		resetDut();
		afterReset();
		fillBeforeInit();
		initSequence();
		fillScreen();
		busyDrop();
		nackRecovery();
		$display("checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, i_dut.i_checker.failCount);
		if (errorCount == 0 && i_dut.i_checker.failCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* dv/oledCtrl_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oledCtrl checker
// I2C framing and handshake assertions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module oledCtrl_checker (
	input logic CLOCK,
	input logic RST_n,
	input logic scl,
	input logic sdaOe,
	input logic done,
	input logic ready,
	input logic busy,
	input logic initOwn	// init engine owns the writer
);
	timeunit 1ns;
	timeprecision 1ps;

	int   failCount = 0;	// assertion failure tally
	logic sclQ, oeQ;
	logic inFrame;	// between start and stop
	logic highChange;	// SDA moved while SCL stayed high

	assign highChange = scl && sclQ && (sdaOe != oeQ);

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			sclQ <= 1'b1;
			oeQ <= 1'b0;
			inFrame <= 1'b0;
		end else begin
			sclQ <= scl;
			oeQ <= sdaOe;
			if (highChange) inFrame <= sdaOe;	// start opens, stop closes
		end
	end

	aStartIdle: assert property (@(posedge CLOCK) disable iff (!RST_n)
		highChange && sdaOe |-> !inFrame)
		else begin
			$error("SDA fell under SCL high inside a frame");
			failCount++;
		end

	aStopInFrame: assert property (@(posedge CLOCK) disable iff (!RST_n)
		highChange && !sdaOe |-> inFrame)
		else begin
			$error("SDA rose under SCL high outside a frame");
			failCount++;
		end

	// idle bus keeps SCL high
	aIdleScl: assert property (@(posedge CLOCK) disable iff (!RST_n) !inFrame |-> scl)
		else begin
			$error("SCL low outside a start/stop frame");
			failCount++;
		end

	aDonePulse: assert property (@(posedge CLOCK) disable iff (!RST_n) done |=> !done)
		else begin
			$error("writer done held longer than one cycle");
			failCount++;
		end

	aFillReady: assert property (@(posedge CLOCK) disable iff (!RST_n)
		$rose(busy) && !initOwn |-> ready)
		else begin
			$error("fill engine went busy without ready");
			failCount++;
		end

endmodule

bind oledCtrl oledCtrl_checker i_checker (
	.CLOCK(CLOCK), .RST_n(RST_n), .scl(i_i2c.scl), .sdaOe(i_i2c.sdaOe),
	.done(i_i2c.done), .ready(i_seq.ready), .busy(i_seq.busy), .initOwn(i_seq.initOwn)
);

/* dv/i2cSlaveModel.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2cSlaveModel
// acking bus model, decodes address,
// control and payload triples
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module i2cSlaveModel (
	input  logic        CLOCK,
	input  logic        RST_n,
	input  logic        scl,
	input  logic        sdaOe,	// master pull-down
	output logic        sda,	// resolved line
	input  logic        nackArm,	// pulse, NACK the next address byte
	output logic        tripleValid,	// one cycle per complete transfer
	output logic [23:0] triple	// address, control, payload
);
	timeunit 1ns;
	timeprecision 1ps;

	logic        sclQ, sdaQ;	// last sampled bus levels
	logic        ackPull;	// slave holds SDA low
	logic        armed;
	logic [3:0]  bitCnt;	// 0..9 within a byte slot
	logic [1:0]  byteIdx;
	logic [7:0]  shift;
	logic [23:0] bytes;

	assign sda = !(sdaOe || ackPull);	// open drain with pull-up

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			sclQ <= 1'b1;
			sdaQ <= 1'b1;
			ackPull <= 1'b0;
			armed <= 1'b0;
			bitCnt <= '0;
			byteIdx <= '0;
			shift <= '0;
			bytes <= '0;
			tripleValid <= 1'b0;
			triple <= '0;
		end else begin
			sclQ <= scl;
			sdaQ <= sda;
			tripleValid <= 1'b0;
			if (nackArm) armed <= 1'b1;
			if (scl && sclQ && sdaQ && !sda) begin	// start
				bitCnt <= '0;
				byteIdx <= '0;
			end else if (scl && sclQ && !sdaQ && sda) begin	// stop
				if (byteIdx == 2'd3) begin
					tripleValid <= 1'b1;
					triple <= bytes;
				end
			end else if (scl && !sclQ) begin	// rising SCL, data valid
				if (bitCnt < 4'd8) shift <= {shift[6:0], sda};
				bitCnt <= bitCnt + 4'd1;
			end else if (!scl && sclQ) begin	// falling SCL
				if (bitCnt == 4'd8) begin	// byte in, ack slot next
					bytes <= {bytes[15:0], shift};
					ackPull <= !(armed && byteIdx == 2'd0);
					if (byteIdx == 2'd0) armed <= 1'b0;
				end else if (bitCnt == 4'd9) begin
					ackPull <= 1'b0;	// release after ack
					bitCnt <= '0;
					byteIdx <= byteIdx + 2'd1;
				end
			end
		end
	end

endmodule

/* source/oledCtrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oledCtrl
// OLED panel controller over I2C
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module oledCtrl #(
	parameter int ClkDiv  = 2,	// quarter SCL period in clocks
	parameter int Pages   = 8,
	parameter int Columns = 128
) (
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       initStart,
	input  logic       fillStart,
	input  logic [7:0] fillData,
	output logic       ready,
	output logic       busy,
	output logic       scl,
	output logic       sdaOe,	// open-drain pull enable
	output logic       ackError,
	input  logic       sdaIn	// resolved SDA from the pad
);

	logic [1:0] call;
	logic [7:0] ctrlByte, dataByte;
	logic       done;

	oledSequencer #(.Pages(Pages), .Columns(Columns)) i_seq (
		.CLOCK(CLOCK), .RST_n(RST_n), .initStart(initStart), .fillStart(fillStart),
		.fillData(fillData), .ready(ready), .busy(busy), .call(call),
		.ctrlByte(ctrlByte), .dataByte(dataByte), .done(done)
	);

	i2cWriter #(.ClkDiv(ClkDiv)) i_i2c (
		.CLOCK(CLOCK), .RST_n(RST_n), .call(call), .ctrlByte(ctrlByte),
		.dataByte(dataByte), .done(done), .scl(scl), .sdaOe(sdaOe),
		.ackError(ackError), .sdaIn(sdaIn)
	);

endmodule

/* source/i2cWriter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2cWriter
// write-only I2C master, one address,
// control and payload triple per request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module i2cWriter import oledPkg::*; #(
	parameter int ClkDiv = 2	// clocks per quarter SCL period
) (
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic [1:0] call,
	input  logic [7:0] ctrlByte,
	input  logic [7:0] dataByte,
	output logic       done,	// one cycle at end of stop
	output logic       scl,
	output logic       sdaOe,	// 1 pulls SDA low
	output logic       ackError,	// sticky NACK flag
	input  logic       sdaIn
);

	localparam int DivW = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;

	typedef enum logic [1:0] {PhIdle, PhStart, PhBits, PhStop} phase_t;

	phase_t          phase;
	logic [DivW-1:0] divCnt;
	logic            tick;	// end of a quarter
	logic [1:0]      quarter;
	logic [4:0]      bitCnt;	// 0..26 over three 9-bit slots
	logic [26:0]     frame;	// ack slots hold 1 so SDA is released
	logic            ackBit;

	assign tick   = (divCnt == DivW'(ClkDiv - 1));
	assign ackBit = (bitCnt == 5'd8) || (bitCnt == 5'd17) || (bitCnt == 5'd26);

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			phase <= PhIdle;
			divCnt <= '0;
			quarter <= '0;
			bitCnt <= '0;
			scl <= 1'b1;
			sdaOe <= 1'b0;
			done <= 1'b0;
			ackError <= 1'b0;
		end else begin
			done <= 1'b0;
			if (phase == PhIdle) begin
				divCnt <= '0;
				quarter <= '0;
				bitCnt <= '0;
				if (call == CallWrite && !done) phase <= PhStart;	// not in the done cycle
			end else begin
				divCnt <= tick ? '0 : divCnt + 1'b1;
				if (tick) begin
					quarter <= quarter + 1'b1;
					case (phase)
						PhStart: begin
							if (quarter == 2'd0) sdaOe <= 1'b1;	// SDA falls, SCL high
							if (quarter == 2'd2) scl <= 1'b0;
							if (quarter == 2'd3) phase <= PhBits;
						end
						PhBits: begin
							case (quarter)
								2'd0: sdaOe <= ~frame[26];	// change mid low phase
								2'd1: scl <= 1'b1;
								2'd2: if (ackBit && sdaIn) ackError <= 1'b1;	// NACK
								default: begin
									scl <= 1'b0;
									bitCnt <= bitCnt + 1'b1;
									if (bitCnt == 5'd26) phase <= PhStop;
								end
							endcase
						end
						default: begin	// stop
							if (quarter == 2'd0) sdaOe <= 1'b1;
							if (quarter == 2'd1) scl <= 1'b1;
							if (quarter == 2'd2) sdaOe <= 1'b0;	// SDA rises, SCL high
							if (quarter == 2'd3) begin
								phase <= PhIdle;
								done <= 1'b1;
							end
						end
					endcase
				end
			end
		end
	end

	// payload frame, loaded at request and shifted per bit
	always_ff @(posedge CLOCK) begin
		if (phase == PhIdle) frame <= {DevAddrW, 1'b1, ctrlByte, 1'b1, dataByte, 1'b1};
		else if (phase == PhBits && tick && quarter == 2'd3) frame <= {frame[25:0], 1'b1};
	end

endmodule

/* source/oledSequencer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oledSequencer
// panel state, start control and writer
// ownership for the two engines
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module oledSequencer #(
	parameter int Pages   = 8,
	parameter int Columns = 128
) (
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       initStart,
	input  logic       fillStart,
	input  logic [7:0] fillData,
	output logic       ready,	// init sequence finished
	output logic       busy,	// an engine owns the writer
	output logic [1:0] call,
	output logic [7:0] ctrlByte,
	output logic [7:0] dataByte,
	input  logic       done
);

	logic       initOwn;	// 1 init engine, 0 fill engine
	logic       initGo, fillGo;	// start pulses, one cycle after accept
	logic       initDone, fillDone;
	logic       initAccept, fillAccept;
	logic [7:0] pattern;
	logic [1:0] initCall, fillCall;
	logic [7:0] initCtrl, fillCtrl, initData, fillData2;

	assign initAccept = initStart && !ready && !busy;
	assign fillAccept = fillStart && ready && !busy;	// dropped otherwise

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			ready <= 1'b0;
			busy <= 1'b0;
			initOwn <= 1'b0;
			initGo <= 1'b0;
			fillGo <= 1'b0;
		end else begin
			initGo <= initAccept;
			fillGo <= fillAccept;
			if (initDone) begin
				ready <= 1'b1;	// held until reset
				busy <= 1'b0;
			end else if (fillDone) begin
				busy <= 1'b0;
			end else if (initAccept || fillAccept) begin
				busy <= 1'b1;
				initOwn <= initAccept;
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		if (fillAccept) pattern <= fillData;	// hold for the whole screen
	end

	oledInit i_init (
		.CLOCK(CLOCK), .RST_n(RST_n), .start(initGo),
		.call(initCall), .ctrlByte(initCtrl), .dataByte(initData),
		.done(done && initOwn), .initDone(initDone)
	);

	oledFill #(.Pages(Pages), .Columns(Columns)) i_fill (
		.CLOCK(CLOCK), .RST_n(RST_n), .start(fillGo), .pattern(pattern),
		.call(fillCall), .ctrlByte(fillCtrl), .dataByte(fillData2),
		.done(done && !initOwn), .fillDone(fillDone)
	);

	// only the owning engine reaches the writer
	assign call     = initOwn ? initCall : fillCall;
	assign ctrlByte = initOwn ? initCtrl : fillCtrl;
	assign dataByte = initOwn ? initData : fillData2;

endmodule

/* source/oledFill.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oledFill
// paints every page and column with one
// pattern byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module oledFill import oledPkg::*; #(
	parameter int Pages   = 8,
	parameter int Columns = 128
) (
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       start,	// one-cycle go
	input  logic [7:0] pattern,	// latched by the sequencer
	output logic [1:0] call,
	output logic [7:0] ctrlByte,
	output logic [7:0] dataByte,
	input  logic       done,
	output logic       fillDone	// pulse after the last column of the last page
);

	localparam int PageW = (Pages > 1) ? $clog2(Pages) : 1;
	localparam int ColW  = (Columns > 1) ? $clog2(Columns) : 1;

	logic             running;
	logic             inData;	// 0 page setup commands, 1 column data
	logic [1:0]       cmdIdx;	// page, low col, high col
	logic [PageW-1:0] page;
	logic [ColW-1:0]  col;

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			running <= 1'b0;
			inData <= 1'b0;
			cmdIdx <= '0;
			page <= '0;
			col <= '0;
			call <= CallIdle;
			fillDone <= 1'b0;
		end else begin
			fillDone <= 1'b0;
			if (!running) begin
				running <= start;
			end else if (call != CallWrite) begin
				call <= CallWrite;
			end else if (done) begin
				call <= CallIdle;
				if (!inData) begin	// setup command sent
					if (cmdIdx == 2'd2) begin
						cmdIdx <= '0;
						inData <= 1'b1;
					end else begin
						cmdIdx <= cmdIdx + 1'b1;
					end
				end else if (col == ColW'(Columns - 1)) begin	// page row complete
					col <= '0;
					inData <= 1'b0;
					if (page == PageW'(Pages - 1)) begin
						page <= '0;
						running <= 1'b0;
						fillDone <= 1'b1;
					end else begin
						page <= page + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	always_comb begin
		ctrlByte = inData ? WrData : WrCmd;
		case (cmdIdx)
			2'd0:    dataByte = 8'hB0 + 8'(page);	// page address
			2'd1:    dataByte = 8'h00;	// column low nibble
			default: dataByte = 8'h10;	// column high nibble
		endcase
		if (inData) dataByte = pattern;
	end

endmodule

/* source/oledInit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oledInit
// walks the power-up table, one command
// transfer per step
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module oledInit import oledPkg::*; (
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       start,	// one-cycle go from the sequencer
	output logic [1:0] call,
	output logic [7:0] ctrlByte,
	output logic [7:0] dataByte,
	input  logic       done,	// writer finished the held request
	output logic       initDone	// pulse after the last command
);

	localparam int StepW = $clog2(InitLen);

	logic             running;	// sequence in progress
	logic [StepW-1:0] step;	// index into initTable

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			running  <= 1'b0;
			step     <= '0;
			call     <= CallIdle;
			initDone <= 1'b0;
		end else begin
			initDone <= 1'b0;	// default, pulse only
			if (!running) begin
				if (start) begin
					running <= 1'b1;
					step    <= '0;
				end
			end else if (call == CallWrite) begin
				if (done) begin	// transfer over, drop the request
					call <= CallIdle;
					if (step == StepW'(InitLen - 1)) begin
						step     <= '0;	// back to the first entry
						running  <= 1'b0;
						initDone <= 1'b1;
					end else begin
						step <= step + 1'b1;
					end
				end
			end else begin
				call <= CallWrite;	// raise request for current step
			end
		end
	end

	// every init byte is a command
	assign ctrlByte = WrCmd;
	assign dataByte = initTable[step];	// stable while step holds

endmodule

/* source/oledPkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oledPkg
// shared bus constants, request codes and
// the panel power-up command table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package oledPkg;

	localparam logic [7:0] WrCmd    = 8'h00;	// control byte, payload is a command
	localparam logic [7:0] WrData   = 8'h40;	// control byte, payload is display data
	localparam logic [7:0] DevAddrW = 8'h78;	// 7-bit 0x3C plus write bit

	localparam logic [1:0] CallIdle  = 2'b00;	// no request
	localparam logic [1:0] CallWrite = 2'b10;	// request one transfer

	localparam int InitLen = 28;	// power-up command count

	// display off, addressing, contrast, remap, mux, clocks, pump, display on
	localparam logic [7:0] initTable [0:InitLen-1] = '{
		8'hAE, 8'h00, 8'h10, 8'h40, 8'h81, 8'hCF, 8'hA1,
		8'hC8, 8'hA6, 8'hA8, 8'h3F, 8'hD3, 8'h00, 8'hD5,
		8'h80, 8'hD9, 8'hF1, 8'hDA, 8'h12, 8'hDB, 8'h40,
		8'h20, 8'h02, 8'h8D, 8'h14, 8'hA4, 8'hA6, 8'hAF
	};

endpackage
